//--- verilog/cache_pkg.sv
package cache_pkg;

   // front-end word and backend lanes
   localparam int data_w  = 32;
   localparam int n_bytes = data_w / 8;

   // 14-bit word address covers 64 KB
   localparam int waddr_w = 14;

   // direct-mapped geometry
   localparam int offset_w   = 2;
   localparam int line_words = 1 << offset_w;
   localparam int index_w    = 4;
   localparam int n_lines    = 1 << index_w;
   localparam int tag_w      = waddr_w - index_w - offset_w;

   // control register map
   localparam int axil_addr_w = 4;

   localparam logic [axil_addr_w-1:0] reg_ctrl   = 4'h0;
   localparam logic [axil_addr_w-1:0] reg_hits   = 4'h4;
   localparam logic [axil_addr_w-1:0] reg_misses = 4'h8;

   localparam int ctrl_inv_bit = 0;

   // cache controller states
   localparam int state_w = 3;

   localparam logic [state_w-1:0] st_idle    = 3'd0;
   localparam logic [state_w-1:0] st_lookup  = 3'd1;
   localparam logic [state_w-1:0] st_fill    = 3'd2;
   localparam logic [state_w-1:0] st_write   = 3'd3;
   localparam logic [state_w-1:0] st_respond = 3'd4;

   // word address, flat for the RAM or split for the lookup
   typedef union packed {
      logic [waddr_w-1:0] flat;
      struct packed {
         logic [tag_w-1:0]    tag;
         logic [index_w-1:0]  index;
         logic [offset_w-1:0] offset;
      } f;
   } cache_addr_t;

endpackage

//--- verilog/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   inv,
   input  logic                   fill_en,
   input  cache_pkg::cache_addr_t lookup_addr,
   input  cache_pkg::cache_addr_t fill_addr,
   output logic                   hit
);

   logic [cache_pkg::n_lines-1:0] valid;
   logic [cache_pkg::tag_w-1:0]   tags [cache_pkg::n_lines];
   logic [cache_pkg::tag_w-1:0]   line_tag;
   logic                          line_valid;

   // valid bits, bulk clear wins over a fill
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid <= '0;
      end else if (inv) begin
         valid <= '0;
      end else if (fill_en) begin
         valid[fill_addr.f.index] <= 1'b1;
      end
   end

   // tag array only matters once valid is set
   always_ff @(posedge clk) begin
      if (fill_en) begin
         tags[fill_addr.f.index] <= fill_addr.f.tag;
      end
   end

   always_comb begin
      line_valid = valid[lookup_addr.f.index];
      line_tag   = tags[lookup_addr.f.index];
   end

   assign hit = line_valid && (line_tag == lookup_addr.f.tag);

endmodule

//--- verilog/cache_core.sv
`timescale 1ns/1ps

module cache_core (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               req,
   input  cache_pkg::cache_addr_t             addr,
   input  logic [cache_pkg::data_w-1:0]       wdata,
   input  logic [cache_pkg::n_bytes-1:0]      wstrb,
   output logic [cache_pkg::data_w-1:0]       rdata,
   output logic                               ack,
   output logic                               mem_req,
   output logic [cache_pkg::waddr_w-1:0]      mem_addr,
   output logic [cache_pkg::data_w-1:0]       mem_wdata,
   output logic [cache_pkg::n_bytes-1:0]      mem_wstrb,
   input  logic [cache_pkg::data_w-1:0]       mem_rdata,
   input  logic                               mem_ack,
   output cache_pkg::cache_addr_t             lookup_addr,
   input  logic                               hit,
   output logic                               fill_en,
   output cache_pkg::cache_addr_t             fill_addr,
   input  logic                               inv_req,
   output logic                               inv,
   output logic                               read_hit,
   output logic                               read_miss
);

   localparam int word_sel_w = cache_pkg::index_w + cache_pkg::offset_w;

   logic [cache_pkg::state_w-1:0]  state;
   logic [cache_pkg::offset_w-1:0] fill_cnt;
   logic                           inv_pend;
   logic                           is_write;
   logic                           last_word;

   cache_pkg::cache_addr_t         addr_q;
   cache_pkg::cache_addr_t         fetch_addr;
   logic [cache_pkg::data_w-1:0]   wdata_q;
   logic [cache_pkg::n_bytes-1:0]  wstrb_q;
   logic [word_sel_w-1:0]          req_word;
   logic [word_sel_w-1:0]          fill_word;

   logic [cache_pkg::data_w-1:0]   data_mem [cache_pkg::n_lines * cache_pkg::line_words];

   assign is_write  = |wstrb_q;
   assign last_word = (fill_cnt == cache_pkg::offset_w'(cache_pkg::line_words - 1));
   assign req_word  = {addr_q.f.index, addr_q.f.offset};
   assign fill_word = {addr_q.f.index, fill_cnt};

   // line fill walks the offsets of the requested line
   always_comb begin
      fetch_addr          = addr_q;
      fetch_addr.f.offset = fill_cnt;
   end

   assign lookup_addr = addr_q;
   assign fill_addr   = addr_q;
   assign fill_en     = (state == cache_pkg::st_fill) && mem_ack && last_word;

   assign mem_addr  = is_write ? addr_q.flat : fetch_addr.flat;
   assign mem_wdata = wdata_q;
   assign mem_wstrb = wstrb_q;

   // invalidate only when nothing is in flight
   assign inv = (state == cache_pkg::st_idle) && inv_pend;

   assign read_hit  = (state == cache_pkg::st_lookup) && !is_write && hit;
   assign read_miss = (state == cache_pkg::st_respond);

   assign ack = read_hit || read_miss ||
                ((state == cache_pkg::st_write) && mem_ack);

   // the whole line is in the array by the time respond is reached
   assign rdata = data_mem[req_word];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= cache_pkg::st_idle;
         mem_req  <= 1'b0;
         fill_cnt <= '0;
         inv_pend <= 1'b0;
      end else begin
         inv_pend <= (inv_pend && !inv) || inv_req;
         mem_req  <= 1'b0;
         case (state)
            cache_pkg::st_idle: begin
               if (req) begin
                  state <= cache_pkg::st_lookup;
               end
            end
            cache_pkg::st_lookup: begin
               if (is_write) begin
                  mem_req <= 1'b1;
                  state   <= cache_pkg::st_write;
               end else if (hit) begin
                  state <= cache_pkg::st_idle;
               end else begin
                  mem_req  <= 1'b1;
                  fill_cnt <= '0;
                  state    <= cache_pkg::st_fill;
               end
            end
            cache_pkg::st_fill: begin
               if (mem_ack) begin
                  if (last_word) begin
                     state <= cache_pkg::st_respond;
                  end else begin
                     fill_cnt <= fill_cnt + 1'b1;
                     mem_req  <= 1'b1;
                  end
               end
            end
            cache_pkg::st_write: begin
               if (mem_ack) begin
                  state <= cache_pkg::st_idle;
               end
            end
            default: begin
               state <= cache_pkg::st_idle;
            end
         endcase
      end
   end

   // request capture and data array
   always_ff @(posedge clk) begin
      if ((state == cache_pkg::st_idle) && req) begin
         addr_q  <= addr;
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
      // write hit merges into the cached copy
      if ((state == cache_pkg::st_lookup) && is_write && hit) begin
         for (int b = 0; b < cache_pkg::n_bytes; b++) begin
            if (wstrb_q[b]) begin
               data_mem[req_word][8*b +: 8] <= wdata_q[8*b +: 8];
            end
         end
      end
      if ((state == cache_pkg::st_fill) && mem_ack) begin
         data_mem[fill_word] <= mem_rdata;
      end
   end

endmodule

//--- verilog/cache_ctrl_regs.sv
`timescale 1ns/1ps

module cache_ctrl_regs (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  read_hit,
   input  logic                                  read_miss,
   input  logic [cache_pkg::axil_addr_w-1:0]     awaddr,
   input  logic                                  awvalid,
   output logic                                  awready,
   input  logic [cache_pkg::data_w-1:0]          wdata,
   input  logic [cache_pkg::n_bytes-1:0]         wstrb,
   input  logic                                  wvalid,
   output logic                                  wready,
   output logic [1:0]                            bresp,
   output logic                                  bvalid,
   input  logic                                  bready,
   input  logic [cache_pkg::axil_addr_w-1:0]     araddr,
   input  logic                                  arvalid,
   output logic                                  arready,
   output logic [cache_pkg::data_w-1:0]          rdata,
   output logic [1:0]                            rresp,
   output logic                                  rvalid,
   input  logic                                  rready,
   output logic                                  inv_req
);

   logic [cache_pkg::data_w-1:0] hit_cnt;
   logic [cache_pkg::data_w-1:0] miss_cnt;
   logic [cache_pkg::data_w-1:0] rd_word;
   logic                         wr_fire;
   logic                         rd_fire;
   logic                         clr_hits;
   logic                         clr_misses;

   assign wr_fire    = awready && awvalid && wready && wvalid;
   assign rd_fire    = arready && arvalid;
   assign clr_hits   = wr_fire && (awaddr == cache_pkg::reg_hits);
   assign clr_misses = wr_fire && (awaddr == cache_pkg::reg_misses);

   // every response is OKAY
   assign bresp = 2'b00;
   assign rresp = 2'b00;

   // write channel: AW and W taken together, one pulse of ready
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         inv_req <= 1'b0;
      end else begin
         awready <= !awready && awvalid && wvalid && !bvalid;
         wready  <= !awready && awvalid && wvalid && !bvalid;
         if (wr_fire) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         // ctrl bit 0 is a command, never stored
         inv_req <= wr_fire && (awaddr == cache_pkg::reg_ctrl) &&
                    wstrb[0] && wdata[cache_pkg::ctrl_inv_bit];
      end
   end

   // read channel: no new address while R is outstanding
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         arready <= !arready && arvalid && !rvalid;
         if (rd_fire) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   always_comb begin
      case (araddr)
         cache_pkg::reg_ctrl:   rd_word = '0;
         cache_pkg::reg_hits:   rd_word = hit_cnt;
         cache_pkg::reg_misses: rd_word = miss_cnt;
         default:               rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rd_fire) begin
         rdata <= rd_word;
      end
   end

   // saturating counters, a write clears and beats the increment
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hit_cnt  <= '0;
         miss_cnt <= '0;
      end else begin
         if (clr_hits) begin
            hit_cnt <= '0;
         end else if (read_hit && (hit_cnt != '1)) begin
            hit_cnt <= hit_cnt + 1'b1;
         end
         if (clr_misses) begin
            miss_cnt <= '0;
         end else if (read_miss && (miss_cnt != '1)) begin
            miss_cnt <= miss_cnt + 1'b1;
         end
      end
   end

endmodule

//--- verilog/backend_ram.sv
`timescale 1ns/1ps

module backend_ram (
   input  logic                               clk,
   input  logic                               mem_req,
   input  logic [cache_pkg::waddr_w-1:0]      mem_addr,
   input  logic [cache_pkg::data_w-1:0]       mem_wdata,
   input  logic [cache_pkg::n_bytes-1:0]      mem_wstrb,
   output logic [cache_pkg::data_w-1:0]       mem_rdata,
   output logic                               mem_ack
);

   localparam int depth = 1 << cache_pkg::waddr_w;

   // starts out all zero
   logic [cache_pkg::data_w-1:0] ram [depth] = '{default: '0};

   // byte lanes written independently
   always_ff @(posedge clk) begin
      if (mem_req) begin
         for (int b = 0; b < cache_pkg::n_bytes; b++) begin
            if (mem_wstrb[b]) begin
               ram[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
            end
         end
      end
   end

   // read word is registered, so it lines up with ack
   always_ff @(posedge clk) begin
      if (mem_req) begin
         mem_rdata <= ram[mem_addr];
      end
   end

   always_ff @(posedge clk) begin
      mem_ack <= mem_req;
   end

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top (
   input  logic                                  clk,
   input  logic                                  rst_n,

   input  logic                                  req,
   input  cache_pkg::cache_addr_t                addr,
   input  logic [cache_pkg::data_w-1:0]          wdata,
   input  logic [cache_pkg::n_bytes-1:0]         wstrb,
   output logic [cache_pkg::data_w-1:0]          rdata,
   output logic                                  ack,

   input  logic [cache_pkg::axil_addr_w-1:0]     s_axil_awaddr,
   input  logic                                  s_axil_awvalid,
   output logic                                  s_axil_awready,
   input  logic [cache_pkg::data_w-1:0]          s_axil_wdata,
   input  logic [cache_pkg::n_bytes-1:0]         s_axil_wstrb,
   input  logic                                  s_axil_wvalid,
   output logic                                  s_axil_wready,
   output logic [1:0]                            s_axil_bresp,
   output logic                                  s_axil_bvalid,
   input  logic                                  s_axil_bready,
   input  logic [cache_pkg::axil_addr_w-1:0]     s_axil_araddr,
   input  logic                                  s_axil_arvalid,
   output logic                                  s_axil_arready,
   output logic [cache_pkg::data_w-1:0]          s_axil_rdata,
   output logic [1:0]                            s_axil_rresp,
   output logic                                  s_axil_rvalid,
   input  logic                                  s_axil_rready
);

   // backend
   logic                              mem_req;
   logic [cache_pkg::waddr_w-1:0]     mem_addr;
   logic [cache_pkg::data_w-1:0]      mem_wdata;
   logic [cache_pkg::n_bytes-1:0]     mem_wstrb;
   logic [cache_pkg::data_w-1:0]      mem_rdata;
   logic                              mem_ack;

   // tag store
   cache_pkg::cache_addr_t            lookup_addr;
   cache_pkg::cache_addr_t            fill_addr;
   logic                              hit;
   logic                              fill_en;
   logic                              inv;

   // register block
   logic                              inv_req;
   logic                              read_hit;
   logic                              read_miss;

   cache_core core0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (req),
      .addr        (addr),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .rdata       (rdata),
      .ack         (ack),
      .mem_req     (mem_req),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .mem_wstrb   (mem_wstrb),
      .mem_rdata   (mem_rdata),
      .mem_ack     (mem_ack),
      .lookup_addr (lookup_addr),
      .hit         (hit),
      .fill_en     (fill_en),
      .fill_addr   (fill_addr),
      .inv_req     (inv_req),
      .inv         (inv),
      .read_hit    (read_hit),
      .read_miss   (read_miss)
   );

   cache_tag_store tags0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .inv         (inv),
      .fill_en     (fill_en),
      .lookup_addr (lookup_addr),
      .fill_addr   (fill_addr),
      .hit         (hit)
   );

   cache_ctrl_regs regs0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .read_hit  (read_hit),
      .read_miss (read_miss),
      .awaddr    (s_axil_awaddr),
      .awvalid   (s_axil_awvalid),
      .awready   (s_axil_awready),
      .wdata     (s_axil_wdata),
      .wstrb     (s_axil_wstrb),
      .wvalid    (s_axil_wvalid),
      .wready    (s_axil_wready),
      .bresp     (s_axil_bresp),
      .bvalid    (s_axil_bvalid),
      .bready    (s_axil_bready),
      .araddr    (s_axil_araddr),
      .arvalid   (s_axil_arvalid),
      .arready   (s_axil_arready),
      .rdata     (s_axil_rdata),
      .rresp     (s_axil_rresp),
      .rvalid    (s_axil_rvalid),
      .rready    (s_axil_rready),
      .inv_req   (inv_req)
   );

   backend_ram ram0 (
      .clk       (clk),
      .mem_req   (mem_req),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ack   (mem_ack)
   );

endmodule

//--- testbench/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

   localparam int timeout_cycles = 100;

   localparam int hs_ack  = 0;
   localparam int hs_aw_w = 1;
   localparam int hs_b    = 2;
   localparam int hs_ar   = 3;
   localparam int hs_r    = 4;

   logic                                 clk;
   logic                                 rst_n;
   logic                                 req;
   cache_pkg::cache_addr_t               addr;
   logic [cache_pkg::data_w-1:0]         wdata;
   logic [cache_pkg::n_bytes-1:0]        wstrb;
   logic [cache_pkg::data_w-1:0]         rdata;
   logic                                 ack;
   logic [cache_pkg::axil_addr_w-1:0]    s_axil_awaddr;
   logic                                 s_axil_awvalid;
   logic                                 s_axil_awready;
   logic [cache_pkg::data_w-1:0]         s_axil_wdata;
   logic [cache_pkg::n_bytes-1:0]        s_axil_wstrb;
   logic                                 s_axil_wvalid;
   logic                                 s_axil_wready;
   logic [1:0]                           s_axil_bresp;
   logic                                 s_axil_bvalid;
   logic                                 s_axil_bready;
   logic [cache_pkg::axil_addr_w-1:0]    s_axil_araddr;
   logic                                 s_axil_arvalid;
   logic                                 s_axil_arready;
   logic [cache_pkg::data_w-1:0]         s_axil_rdata;
   logic [1:0]                           s_axil_rresp;
   logic                                 s_axil_rvalid;
   logic                                 s_axil_rready;

   // reference model of backend memory, tags and counters
   logic [cache_pkg::data_w-1:0]  mem_model [1 << cache_pkg::waddr_w];
   logic [cache_pkg::tag_w-1:0]   tag_model [cache_pkg::n_lines];
   logic [cache_pkg::n_lines-1:0] valid_model;
   int                            hit_model;
   int                            miss_model;

   int    errors;
   int    n_tests;
   int    n_failed;
   bit    aborted;
   string test_name;

   cache_top dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
      logic [31:0] res;
      res = old_word;
      for (int b = 0; b < cache_pkg::n_bytes; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return res;
   endfunction

   function automatic logic handshake_seen(input int which);
      case (which)
         hs_ack:  return ack;
         hs_aw_w: return s_axil_awready && s_axil_wready;
         hs_b:    return s_axil_bvalid;
         hs_ar:   return s_axil_arready;
         default: return s_axil_rvalid;
      endcase
   endfunction

   // outputs are sampled at the falling edge
   task automatic wait_handshake(input int which, input string what);
      int n;
      n = 0;
      @(negedge clk);
      while (!handshake_seen(which) && n < timeout_cycles) begin
         @(negedge clk);
         n++;
      end
      if (!handshake_seen(which)) begin
         $display("%s: the %s never completed within %0d cycles",
                  test_name, what, timeout_cycles);
         aborted = 1'b1;
      end
   endtask

   task automatic front_access(input cache_pkg::cache_addr_t a, input logic [31:0] d,
                               input logic [3:0] s, output logic [31:0] rd);
      @(posedge clk);
      req   <= 1'b1;
      addr  <= a;
      wdata <= d;
      wstrb <= s;
      wait_handshake(hs_ack, "front-end ack");
      rd = rdata;
      @(posedge clk);
      req   <= 1'b0;
      wstrb <= '0;
   endtask

   task automatic axil_write(input logic [3:0] a, input logic [31:0] d,
                             input logic [3:0] s, output logic [1:0] resp);
      resp = 2'b11;
      @(posedge clk);
      s_axil_awaddr  <= a;
      s_axil_awvalid <= 1'b1;
      s_axil_wdata   <= d;
      s_axil_wstrb   <= s;
      s_axil_wvalid  <= 1'b1;
      s_axil_bready  <= 1'b1;
      wait_handshake(hs_aw_w, "AW/W handshake");
      @(posedge clk);
      s_axil_awvalid <= 1'b0;
      s_axil_wvalid  <= 1'b0;
      if (!aborted) begin
         wait_handshake(hs_b, "B response");
         resp = s_axil_bresp;
      end
      @(posedge clk);
      s_axil_bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [3:0] a, output logic [31:0] d,
                            output logic [1:0] resp);
      d    = '0;
      resp = 2'b11;
      @(posedge clk);
      s_axil_araddr  <= a;
      s_axil_arvalid <= 1'b1;
      s_axil_rready  <= 1'b1;
      wait_handshake(hs_ar, "AR handshake");
      @(posedge clk);
      s_axil_arvalid <= 1'b0;
      if (!aborted) begin
         wait_handshake(hs_r, "R response");
         d    = s_axil_rdata;
         resp = s_axil_rresp;
      end
      @(posedge clk);
      s_axil_rready <= 1'b0;
   endtask

   task automatic check_value(input logic [31:0] expected, input logic [31:0] model_val,
                              input logic [31:0] got);
      assert (expected == model_val) else begin
         $display("ERROR %s: test file expects %h, reference model %h",
                  test_name, expected, model_val);
         errors++;
      end
      assert (got == expected) else begin
         $display("ERROR %s: expected %h, actual %h", test_name, expected, got);
         errors++;
      end
   endtask

   task automatic check_resp(input logic [1:0] resp);
      assert (resp == 2'b00) else begin
         $display("ERROR %s: expected resp 0, actual resp %0d", test_name, resp);
         errors++;
      end
   endtask

   task automatic run_test(input string op, input logic [31:0] a, input logic [31:0] d,
                           input logic [31:0] s, input logic [31:0] e);
      cache_pkg::cache_addr_t ma;
      logic [31:0]            got;
      logic [31:0]            model_val;
      logic [1:0]             resp;
      int                     errors_before;
      errors_before = errors;
      ma.flat       = a[cache_pkg::waddr_w-1:0];
      model_val     = '0;
      if (op == "FW") begin
         front_access(ma, d, s[3:0], got);
         mem_model[ma.flat] = merge_bytes(mem_model[ma.flat], d, s[3:0]);
      end else if (op == "FR") begin
         // reads allocate, writes never do
         if (valid_model[ma.f.index] && (tag_model[ma.f.index] == ma.f.tag)) begin
            hit_model++;
         end else begin
            miss_model++;
            valid_model[ma.f.index] = 1'b1;
            tag_model[ma.f.index]   = ma.f.tag;
         end
         model_val = mem_model[ma.flat];
         front_access(ma, '0, '0, got);
         check_value(e, model_val, got);
      end else if (op == "CW") begin
         axil_write(a[3:0], d, s[3:0], resp);
         if ((a[3:0] == cache_pkg::reg_ctrl) && s[0] && d[cache_pkg::ctrl_inv_bit]) begin
            valid_model = '0;
         end
         if (a[3:0] == cache_pkg::reg_hits) hit_model = 0;
         if (a[3:0] == cache_pkg::reg_misses) miss_model = 0;
         check_resp(resp);
      end else if (op == "CR") begin
         if (a[3:0] == cache_pkg::reg_hits) model_val = hit_model;
         if (a[3:0] == cache_pkg::reg_misses) model_val = miss_model;
         axil_read(a[3:0], got, resp);
         check_value(e, model_val, got);
         check_resp(resp);
      end else begin
         $display("%s: unknown operation %s in the test file", test_name, op);
         errors++;
      end
      n_tests++;
      if (errors != errors_before) n_failed++;
      $display("%-16s %s %s", test_name, op, (errors == errors_before) ? "ok" : "failed");
   endtask

   initial begin
      int          fd;
      int          n;
      string       line;
      string       op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] s;
      logic [31:0] e;
      void'($urandom(32'h9722));
      rst_n          = 1'b0;
      req            = 1'b0;
      addr           = '0;
      wdata          = '0;
      wstrb          = '0;
      s_axil_awaddr  = '0;
      s_axil_awvalid = 1'b0;
      s_axil_wdata   = '0;
      s_axil_wstrb   = '0;
      s_axil_wvalid  = 1'b0;
      s_axil_bready  = 1'b0;
      s_axil_araddr  = '0;
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b0;
      for (int i = 0; i < (1 << cache_pkg::waddr_w); i++) mem_model[i] = '0;
      valid_model = '0;
      hit_model   = 0;
      miss_model  = 0;
      errors      = 0;
      n_tests     = 0;
      n_failed    = 0;
      aborted     = 1'b0;
      test_name   = "setup";
      fd = $fopen("testbench/cache_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open testbench/cache_tests.txt");
         aborted = 1'b1;
      end
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      while (fd != 0 && !aborted && !$feof(fd)) begin
         if ($fgets(line, fd) == 0) break;
         if (line.len() == 0 || line.getc(0) == "#") continue;
         n = $sscanf(line, "%s %s %h %h %h %h", test_name, op, a, d, s, e);
         if (n != 6) continue;
         // idle gap of 0 to 3 cycles
         repeat ($urandom % 4) @(posedge clk);
         run_test(op, a, d, s, e);
      end
      if (fd != 0) $fclose(fd);
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               n_tests, n_tests - n_failed, n_failed, errors);
      if (aborted || errors != 0 || n_tests == 0) begin
         $display("TEST RESULT: FAIL");
      end else begin
         $display("TEST RESULT: PASS");
      end
      $finish;
   end

endmodule

//--- testbench/cache_tests.txt
# name op addr data strobe expected, all values hex
# FW/FR take a front-end word address, CW/CR a register offset
t1_cold_miss    FR 0040 00000000 0 00000000
t1_same_line    FR 0042 00000000 0 00000000
t1_hit_count    CR 4    00000000 0 00000001
t1_miss_count   CR 8    00000000 0 00000001
t2_part_write   FW 0105 a1b2c3d4 5 00000000
t2_read_back    FR 0105 00000000 0 00b200d4
t2_miss_count   CR 8    00000000 0 00000002
t3_write_word   FW 0106 11223344 f 00000000
t3_write_byte   FW 0105 ffeeddcc 2 00000000
t3_read_word    FR 0106 00000000 0 11223344
t3_read_byte    FR 0105 00000000 0 00b2ddd4
t3_hit_count    CR 4    00000000 0 00000003
t4_invalidate   CW 0    00000001 f 00000000
t4_ctrl_clear   CR 0    00000000 0 00000000
t4_refill       FR 0106 00000000 0 11223344
t4_hit_again    FR 0105 00000000 0 00b2ddd4
t4_miss_count   CR 8    00000000 0 00000003
t4_hit_count    CR 4    00000000 0 00000004
t5_seed_a       FW 0208 cafe0001 f 00000000
t5_seed_b       FW 0309 beef0002 f 00000000
t5_read_a1      FR 0208 00000000 0 cafe0001
t5_read_b1      FR 0309 00000000 0 beef0002
t5_read_a2      FR 0208 00000000 0 cafe0001
t5_read_b2      FR 0309 00000000 0 beef0002
t5_miss_count   CR 8    00000000 0 00000007
t5_hit_count    CR 4    00000000 0 00000004
t6_clear_hits   CW 4    00000000 f 00000000
t6_clear_misses CW 8    00000000 f 00000000
t6_hits_zero    CR 4    00000000 0 00000000
t6_misses_zero  CR 8    00000000 0 00000000
t6_unmapped     CR c    00000000 0 00000000

//--- sim.f
verilog/cache_pkg.sv
verilog/cache_tag_store.sv
verilog/cache_core.sv
verilog/cache_ctrl_regs.sv
verilog/backend_ram.sv
verilog/cache_top.sv
testbench/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - files:
      - verilog/cache_pkg.sv
      - verilog/cache_tag_store.sv
      - verilog/cache_core.sv
      - verilog/cache_ctrl_regs.sv
      - verilog/backend_ram.sv
      - verilog/cache_top.sv
  - target: test
    files:
      - testbench/cache_tb.sv
